//--- vlog.f
hw/cu_setup_pkg.sv
hw/setup_read_engine.sv
hw/request_fifo.sv
hw/setup_controller.sv
hw/cu_setup.sv
sim/tb_clock_gen.sv
sim/cu_setup_tb.sv

//--- Bender.yml
package:
  name: cu_setup

sources:
  - files:
      - hw/cu_setup_pkg.sv
      - hw/setup_read_engine.sv
      - hw/request_fifo.sv
      - hw/setup_controller.sv
      - hw/cu_setup.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/cu_setup_tb.sv

//--- sim/cu_setup_tb.sv
// Top of the setup reader simulation with directed tests and a memory response model
`timescale 1ns/1ps

module cu_setup_tb;
    import cu_setup_pkg::*;

    // Words over all tests for sizing the watchdog
    localparam int RUN_WORDS       = 12 + 44 + 8 + 6;
    localparam int WATCHDOG_CYCLES = RUN_WORDS * 40 + 2000;
    localparam int RESPONSE_DELAY  = 4;
    localparam int NO_LIMIT        = 32'h7fff_ffff;

    logic   ap_clk;
    logic   areset_cu_setup;
    logic   descriptor_valid;
    addr_t  descriptor_base;
    count_t descriptor_setup_words;
    count_t descriptor_total_words;
    logic   cu_flush;
    logic   response_valid;
    logic   request_ready;
    logic   request_valid;
    addr_t  request_addr;
    logic   request_flush;
    logic   done;

    string  test_name;
    integer seed;
    int     error_count;
    int     cycle;
    int     responses_sent;
    int     response_limit;
    int     done_count;
    int     stall_left;
    logic   stall_enable;
    addr_t  accepted_addr[$];
    logic   accepted_flush[$];
    int     response_due[$];

    tb_clock_gen u_clock_gen (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup)
    );

    cu_setup DUT (.*);

    task automatic stop_with_failure(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first failure");
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_addr(input string what, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR %s %s: expected %h, actual %h",
                                        test_name, what, expected, actual));
        end
    endtask

    task automatic check_count(input string what, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR %s %s: expected %0d, actual %0d",
                                        test_name, what, expected, actual));
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR %s %s: expected %b, actual %b",
                                        test_name, what, expected, actual));
        end
    endtask

    // --------------------------------------------------
    // Memory side model
    // --------------------------------------------------
    // Random ready stalls and one response a fixed delay after each accepted request
    initial begin
        forever begin
            @(posedge ap_clk);
            #2;
            cycle++;
            response_valid = 1'b0;
            if ((response_due.size() > 0) && (response_due[0] <= cycle) &&
                (responses_sent < response_limit)) begin
                response_valid = 1'b1;
                void'(response_due.pop_front());
                responses_sent++;
            end
            if (done === 1'b1) begin
                done_count++;
            end
            if (stall_left > 0) begin
                stall_left--;
            end else if (stall_enable && (($random(seed) & 7) == 0)) begin
                // Every stall outlasts the whole request queue
                stall_left = FIFO_DEPTH + ($random(seed) & 31);
            end
            request_ready = (stall_left == 0);
            // Transfer happens at the next edge with these stable values
            if ((request_valid === 1'b1) && request_ready) begin
                accepted_addr.push_back(request_addr);
                accepted_flush.push_back(request_flush);
                response_due.push_back(cycle + RESPONSE_DELAY);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        stop_with_failure("The run timed out before all tests finished");
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic send_descriptor(input addr_t base, input count_t setup_words,
                                   input count_t total_words);
        @(posedge ap_clk);
        accepted_addr.delete();
        accepted_flush.delete();
        responses_sent = 0;
        done_count     = 0;
        #2;
        descriptor_valid       = 1'b1;
        descriptor_base        = base;
        descriptor_setup_words = setup_words;
        descriptor_total_words = total_words;
        @(posedge ap_clk);
        #2;
        descriptor_valid = 1'b0;
    endtask

    task automatic raise_flush();
        @(posedge ap_clk);
        #2;
        cu_flush = 1'b1;
        @(posedge ap_clk);
        #2;
        cu_flush = 1'b0;
    endtask

    task automatic wait_for_traffic(input int n_req, input int n_resp);
        int waited;
        waited = 0;
        while ((accepted_addr.size() < n_req) || (responses_sent < n_resp)) begin
            @(posedge ap_clk);
            waited++;
            if (waited > n_req * 40 + 200) begin
                stop_with_failure($sformatf("%s: requests or responses stopped arriving",
                                            test_name));
            end
        end
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (done_count == 0) begin
            @(posedge ap_clk);
            waited++;
            if (waited > 200) begin
                stop_with_failure($sformatf("%s: done never pulsed", test_name));
            end
        end
    endtask

    // Word i of a descriptor lands at base plus i words
    task automatic compare_words(input addr_t base, input count_t first, input count_t last,
                                 input logic flush);
        for (int i = first; i < last; i++) begin
            check_addr($sformatf("address of word %0d", i),
                       base + (addr_t'(i) << WORD_SHIFT), accepted_addr[i]);
            check_bit($sformatf("flush tag of word %0d", i), flush, accepted_flush[i]);
        end
    endtask

    task automatic run_two_phases(input addr_t base, input count_t setup_words,
                                  input count_t total_words);
        send_descriptor(base, setup_words, total_words);
        wait_for_traffic(setup_words, setup_words);
        // Long enough to reach the flush wait
        repeat (10) @(posedge ap_clk);
        check_count("requests before flush", setup_words, count_t'(accepted_addr.size()));
        compare_words(base, '0, setup_words, 1'b0);
        raise_flush();
        wait_for_traffic(total_words, total_words);
        wait_for_done();
        repeat (10) @(posedge ap_clk);
        check_count("requests after flush", total_words, count_t'(accepted_addr.size()));
        compare_words(base, setup_words, total_words, 1'b1);
        check_count("done pulses", 1, count_t'(done_count));
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_quiet();
        test_name = "reset";
        repeat (20) begin
            @(negedge ap_clk);
            check_bit("request_valid", 1'b0, request_valid);
            check_bit("done", 1'b0, done);
        end
    endtask

    task automatic setup_then_flush();
        test_name = "setup_then_flush";
        run_two_phases(64'h0000_0040_1234_5600, 5, 12);
    endtask

    task automatic stress_back_pressure();
        test_name    = "back_pressure";
        stall_enable = 1'b1;
        // Crosses the 32-bit address boundary on the way
        run_two_phases(64'h0000_0000_ffff_ff80, 40, 44);
        stall_enable = 1'b0;
    endtask

    task automatic hold_last_response();
        test_name      = "withheld_response";
        response_limit = 7;
        send_descriptor(64'h8000_0000_0000_1000, 3, 8);
        wait_for_traffic(3, 3);
        repeat (10) @(posedge ap_clk);
        raise_flush();
        wait_for_traffic(8, 7);
        repeat (30) @(posedge ap_clk);
        check_count("done pulses while withheld", 0, count_t'(done_count));
        check_count("responses given", 7, count_t'(responses_sent));
        response_limit = NO_LIMIT;
        wait_for_done();
        repeat (10) @(posedge ap_clk);
        check_count("done pulses", 1, count_t'(done_count));
        compare_words(64'h8000_0000_0000_1000, 3, 8, 1'b1);
    endtask

    task automatic send_back_to_back();
        test_name = "back_to_back";
        run_two_phases(64'h0000_0000_0002_0000, 0, 6);
    endtask

    initial begin
        seed                   = 84;
        error_count            = 0;
        cycle                  = 0;
        responses_sent         = 0;
        response_limit         = NO_LIMIT;
        done_count             = 0;
        stall_left             = 0;
        stall_enable           = 1'b0;
        test_name              = "startup";
        descriptor_valid       = 1'b0;
        descriptor_base        = '0;
        descriptor_setup_words = '0;
        descriptor_total_words = '0;
        cu_flush               = 1'b0;
        response_valid         = 1'b0;
        request_ready          = 1'b1;
        wait (areset_cu_setup === 1'b0);
        reset_quiet();
        setup_then_flush();
        stress_back_pressure();
        hold_last_response();
        send_back_to_back();
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "simulation ended with failures");
        end
    end

endmodule

//--- sim/tb_clock_gen.sv
// Clock and power-on reset source for the setup reader testbench, instantiated by its top module
`timescale 1ns/1ps

module tb_clock_gen (
    output logic ap_clk,
    output logic areset_cu_setup
);
    localparam int RESET_CYCLES = 8;

    // 20 ns period
    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // Release lines up with the 2 ns stimulus offset
    initial begin
        areset_cu_setup = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #2;
        areset_cu_setup = 1'b0;
    end

endmodule

//--- hw/cu_setup.sv
// Top level of the setup reader: connects sequencer, address walker and request queue
`timescale 1ns/1ps

module cu_setup (
    input  logic                 ap_clk,
    input  logic                 areset_cu_setup,
    input  logic                 descriptor_valid,
    input  cu_setup_pkg::addr_t  descriptor_base,
    input  cu_setup_pkg::count_t descriptor_setup_words,
    input  cu_setup_pkg::count_t descriptor_total_words,
    input  logic                 cu_flush,
    input  logic                 response_valid,
    input  logic                 request_ready,
    output logic                 request_valid,
    output cu_setup_pkg::addr_t  request_addr,
    output logic                 request_flush,
    output logic                 done
);
    import cu_setup_pkg::*;

    // Sequencer to walker
    logic   engine_start;
    logic   engine_flush;
    addr_t  engine_base;
    count_t engine_first_index;
    count_t engine_last_index;
    logic   engine_pause;
    logic   engine_busy;

    // Walker to queue
    logic   push;
    addr_t  push_addr;
    logic   push_flush;

    // Queue status
    logic   fifo_empty;
    logic   fifo_prog_full;

    setup_controller u_setup_controller (
        .ap_clk                 (ap_clk),
        .areset_cu_setup        (areset_cu_setup),
        .descriptor_valid       (descriptor_valid),
        .descriptor_base        (descriptor_base),
        .descriptor_setup_words (descriptor_setup_words),
        .descriptor_total_words (descriptor_total_words),
        .cu_flush               (cu_flush),
        .response_valid         (response_valid),
        .engine_busy            (engine_busy),
        .fifo_empty             (fifo_empty),
        .fifo_prog_full         (fifo_prog_full),
        .engine_start           (engine_start),
        .engine_flush           (engine_flush),
        .engine_base            (engine_base),
        .engine_first_index     (engine_first_index),
        .engine_last_index      (engine_last_index),
        .engine_pause           (engine_pause),
        .done                   (done)
    );

    setup_read_engine u_setup_read_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .start           (engine_start),
        .flush           (engine_flush),
        .base            (engine_base),
        .first_index     (engine_first_index),
        .last_index      (engine_last_index),
        .pause           (engine_pause),
        .busy            (engine_busy),
        .push            (push),
        .push_addr       (push_addr),
        .push_flush      (push_flush)
    );

    request_fifo u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (push),
        .push_addr       (push_addr),
        .push_flush      (push_flush),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request_addr    (request_addr),
        .request_flush   (request_flush),
        .empty           (fifo_empty),
        .prog_full       (fifo_prog_full)
    );

endmodule

//--- hw/setup_controller.sv
// Two-phase sequencer: takes the descriptor, starts the walker per phase and counts responses
`timescale 1ns/1ps

module setup_controller (
    input  logic                 ap_clk,
    input  logic                 areset_cu_setup,
    input  logic                 descriptor_valid,
    input  cu_setup_pkg::addr_t  descriptor_base,
    input  cu_setup_pkg::count_t descriptor_setup_words,
    input  cu_setup_pkg::count_t descriptor_total_words,
    input  logic                 cu_flush,
    input  logic                 response_valid,
    input  logic                 engine_busy,
    input  logic                 fifo_empty,
    input  logic                 fifo_prog_full,
    output logic                 engine_start,
    output logic                 engine_flush,
    output cu_setup_pkg::addr_t  engine_base,
    output cu_setup_pkg::count_t engine_first_index,
    output cu_setup_pkg::count_t engine_last_index,
    output logic                 engine_pause,
    output logic                 done
);
    import cu_setup_pkg::*;

    setup_state_e state;
    setup_state_e next_state;

    addr_t  desc_base;
    count_t desc_setup_words;
    count_t desc_total_words;

    count_t resp_count;
    logic   resp_zero;
    logic   phase_clear;
    logic   flush_mode;

    assign resp_zero = (resp_count == '0);
    // Walker finished, queue drained and every response back
    assign phase_clear = ~engine_busy & fifo_empty & resp_zero;

    // --------------------------------------------------
    // Phase state machine
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SETUP_RESET:          next_state = SETUP_IDLE;
            SETUP_IDLE:           if (descriptor_valid) next_state = SETUP_REQ_START;
            SETUP_REQ_START:      next_state = SETUP_REQ_BUSY;
            SETUP_REQ_BUSY:       if (!engine_busy) next_state = SETUP_REQ_WAIT;
            SETUP_REQ_WAIT:       if (phase_clear) next_state = SETUP_FLUSH_WAIT_CMD;
            SETUP_FLUSH_WAIT_CMD: if (cu_flush) next_state = SETUP_FLUSH_START;
            SETUP_FLUSH_START:    next_state = SETUP_FLUSH_BUSY;
            SETUP_FLUSH_BUSY:     if (!engine_busy) next_state = SETUP_FLUSH_WAIT;
            SETUP_FLUSH_WAIT:     if (phase_clear) next_state = SETUP_DONE;
            SETUP_DONE:           next_state = SETUP_IDLE;
            default:              next_state = SETUP_RESET;
        endcase
    end

    // Descriptor is only taken while idle
    always_ff @(posedge ap_clk) begin
        if ((state == SETUP_IDLE) && descriptor_valid) begin
            desc_base        <= descriptor_base;
            desc_setup_words <= descriptor_setup_words;
            desc_total_words <= descriptor_total_words;
        end
    end

    // --------------------------------------------------
    // Response counter
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            resp_count <= '0;
        end else if (state == SETUP_REQ_START) begin
            resp_count <= desc_setup_words;
        end else if (state == SETUP_FLUSH_START) begin
            resp_count <= desc_total_words - desc_setup_words;
        end else if (response_valid && !resp_zero) begin
            // Late responses past zero are ignored
            resp_count <= resp_count - count_t'(1);
        end
    end

    // Back-pressure from the request queue, one cycle behind
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            engine_pause <= 1'b0;
        end else begin
            engine_pause <= fifo_prog_full;
        end
    end

    // --------------------------------------------------
    // Walker command
    // --------------------------------------------------
    assign flush_mode = (state == SETUP_FLUSH_START) || (state == SETUP_FLUSH_BUSY) ||
                        (state == SETUP_FLUSH_WAIT);

    assign engine_start       = (state == SETUP_REQ_START) || (state == SETUP_FLUSH_START);
    assign engine_flush       = flush_mode;
    assign engine_base        = desc_base;
    // Setup covers [0, setup), flush covers [setup, total)
    assign engine_first_index = flush_mode ? desc_setup_words : '0;
    assign engine_last_index  = flush_mode ? desc_total_words : desc_setup_words;

    assign done = (state == SETUP_DONE);

endmodule

//--- hw/request_fifo.sv
// Request queue between the address walker and the memory side, with a fill threshold for pausing
`timescale 1ns/1ps

module request_fifo (
    input  logic                ap_clk,
    input  logic                areset_cu_setup,
    input  logic                push,
    input  cu_setup_pkg::addr_t push_addr,
    input  logic                push_flush,
    input  logic                request_ready,
    output logic                request_valid,
    output cu_setup_pkg::addr_t request_addr,
    output logic                request_flush,
    output logic                empty,
    output logic                prog_full
);
    import cu_setup_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    addr_t            mem_addr  [FIFO_DEPTH];
    logic             mem_flush [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_level_t      level;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full  = (level == fifo_level_t'(FIFO_DEPTH));
    assign empty = (level == '0);
    // Writes into a full queue are dropped; the pause margin keeps this from happening
    assign wr_en = push & ~full;
    assign rd_en = request_valid & request_ready;

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem_addr[wr_ptr]  <= push_addr;
            mem_flush[wr_ptr] <= push_flush;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Head entry presented directly
    assign request_valid = ~empty;
    assign request_addr  = mem_addr[rd_ptr];
    assign request_flush = mem_flush[rd_ptr];
    assign prog_full     = (level >= fifo_level_t'(FIFO_PROG_THRESH));

endmodule

//--- hw/setup_read_engine.sv
// Address walker for one phase: emits one word address per unpaused cycle into the request FIFO
`timescale 1ns/1ps

module setup_read_engine (
    input  logic                 ap_clk,
    input  logic                 areset_cu_setup,
    input  logic                 start,
    input  logic                 flush,
    input  cu_setup_pkg::addr_t  base,
    input  cu_setup_pkg::count_t first_index,
    input  cu_setup_pkg::count_t last_index,
    input  logic                 pause,
    output logic                 busy,
    output logic                 push,
    output cu_setup_pkg::addr_t  push_addr,
    output logic                 push_flush
);
    import cu_setup_pkg::*;

    addr_t  base_reg;
    count_t index;
    count_t next_index;
    count_t last_reg;
    logic   flush_reg;
    logic   busy_reg;
    logic   step;
    addr_t  offset;

    // One word per cycle unless held off by the controller
    assign step       = busy_reg & ~pause;
    assign next_index = index + count_t'(1);

    // Word index to byte offset
    assign offset = addr_t'(index) << WORD_SHIFT;

    // --------------------------------------------------
    // Busy flag
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            busy_reg <= 1'b0;
        end else if (start) begin
            // Empty range never goes busy
            busy_reg <= (first_index < last_index);
        end else if (step && (next_index == last_reg)) begin
            busy_reg <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Range and walk position
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (start) begin
            base_reg  <= base;
            index     <= first_index;
            last_reg  <= last_index;
            flush_reg <= flush;
        end else if (step) begin
            index <= next_index;
        end
    end

    assign busy       = busy_reg;
    assign push       = step;
    assign push_addr  = base_reg + offset;
    assign push_flush = flush_reg;

endmodule

//--- hw/cu_setup_pkg.sv
// Shared widths, FIFO constants, vector types and controller states, imported by every RTL block
package cu_setup_pkg;

    // --------------------------------------------------
    // Widths and constants
    // --------------------------------------------------
    localparam int ADDR_W           = 64;
    localparam int COUNT_W          = 32;
    // Four bytes per word
    localparam int WORD_SHIFT       = 2;
    localparam int FIFO_DEPTH       = 32;
    localparam int FIFO_PROG_THRESH = 16;
    // Holds 0 up to FIFO_DEPTH inclusive
    localparam int FIFO_LEVEL_W     = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [COUNT_W-1:0]      count_t;
    typedef logic [FIFO_LEVEL_W-1:0] fifo_level_t;

    typedef enum logic [3:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_REQ_WAIT,
        SETUP_FLUSH_WAIT_CMD,
        SETUP_FLUSH_START,
        SETUP_FLUSH_BUSY,
        SETUP_FLUSH_WAIT,
        SETUP_DONE
    } setup_state_e;

endpackage
